/* include/tart_consts.svh */
`ifndef TART_CONSTS_SVH
`define TART_CONSTS_SVH

// ----------------------------------------
// Capture path
// ----------------------------------------
`define TART_NUM_ANT          24   // Antenna bus and sample width
`define TART_SAMPLE_DIV       6    // fpga_clk cycles per receiver sample
`define TART_BUF_AW           9    // 512 sample block buffer
`define TART_DELAY_W          3    // Sample phase setting width
`define TART_TEST_PIN_HI      3    // Test pin high cycles per period
`define TART_SRST_DEPTH       3    // Soft reset delay flops

// ----------------------------------------
// SPI register map
// ----------------------------------------
`define TART_SPI_BITS         8    // Bits per SPI byte
`define TART_CMD_WR_BIT       7    // Write flag in command byte
`define TART_CTRL_START       0    // Start pulse, reads back 0
`define TART_CTRL_DEBUG       1    // Test counter select
`define TART_CTRL_SRST        7    // Soft reset pulse, reads back 0
`define TART_STATUS_MARK      7    // Always 1 in status byte
`define TART_STAT_DEBUG       4
`define TART_STAT_FULL        3
`define TART_BYTES_PER_SAMPLE 3    // REG_DATA bytes per sample

`endif

/* hw/tart_pkg.sv */
package tart_pkg;

   // ----------------------------------------
   // Capture scheduler
   // ----------------------------------------

   // Visible to host in status bits 2..0
   typedef enum logic [2:0]
   {
      ST_IDLE    = 3'd0,   // Waiting for start
      ST_CAPTURE = 3'd1,   // Filling buffer
      ST_FULL    = 3'd2,   // 512 samples held, nothing read yet
      ST_DRAIN   = 3'd3    // Host streaming samples out
   } acq_state_t;

   // ----------------------------------------
   // SPI register addresses
   // ----------------------------------------

   // Command byte bits 2..0
   typedef enum logic [2:0]
   {
      REG_STATUS  = 3'd0,  // RO
      REG_CONTROL = 3'd1,  // RW, start and soft reset self clear
      REG_DELAY   = 3'd2,  // RW, sample phase
      REG_DATA    = 3'd3   // RO, three bytes per sample
   } spi_reg_t;

endpackage

/* hw/sample_store.sv */
`timescale 1ns/1ps
`include "tart_consts.svh"

module sample_store
#(
   parameter int DW = `TART_NUM_ANT,   // Sample width
   parameter int AW = `TART_BUF_AW     // Address width
)
(
   input  logic          fpga_clk,
   input  logic          wr_en,
   input  logic [AW-1:0] wr_addr,
   input  logic [AW-1:0] rd_addr,
   input  logic [DW-1:0] wr_data,
   output logic [DW-1:0] rd_data     // Valid one cycle after rd_addr
);

   localparam int DEPTH = 1 << AW;

   // ----------------------------------------
   // Block RAM array
   // ----------------------------------------
   logic [DW-1:0] mem [0:DEPTH-1];

   // Write port, capture side
   always_ff @(posedge fpga_clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Read port, registered for BRAM inference
   always_ff @(posedge fpga_clk)
   begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* hw/antenna_capture.sv */
`timescale 1ns/1ps
`include "tart_consts.svh"

module antenna_capture
(
   input  logic                     fpga_clk,
   input  logic                     rst_n,
   input  logic [`TART_NUM_ANT-1:0] antenna,          // Raw antenna pins
   input  logic                     debug_sel,        // 1 picks test counter
   input  logic [`TART_DELAY_W-1:0] sample_delay,     // Strobe phase 0..5
   output logic                     sample_stb,       // One cycle per period
   output logic [`TART_NUM_ANT-1:0] sample_word,
   output logic                     rx_clk_test_pin   // Scope view of receiver clock
);

   localparam int PW = `TART_DELAY_W;
   localparam logic [PW-1:0] PHASE_MAX = PW'(`TART_SAMPLE_DIV - 1);

   logic [PW-1:0]            phase;      // Free running 0..5
   logic [PW-1:0]            eff_delay;  // Clamped delay
   logic [PW-1:0]            gap_cnt;    // Cycles since last strobe, saturating
   logic [1:0]               hi_cnt;     // Remaining test pin high cycles
   logic [`TART_NUM_ANT-1:0] ant_q;      // Input register
   logic [`TART_NUM_ANT-1:0] test_cnt;   // Fake telescope data

   // ----------------------------------------
   // Receiver period and strobe
   // ----------------------------------------
   assign eff_delay  = (sample_delay > PHASE_MAX) ? PHASE_MAX : sample_delay;  // 6, 7 act as 5
   // Gap guard drops a strobe that a delay change would bring too close
   assign sample_stb = (phase == eff_delay) && (gap_cnt == PHASE_MAX);

   always_ff @(posedge fpga_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         phase   <= '0;
         gap_cnt <= PHASE_MAX;   // First strobe allowed at once
         hi_cnt  <= '0;
      end
      else
      begin
         phase <= (phase == PHASE_MAX) ? '0 : phase + 1'b1;
         if (sample_stb)
            gap_cnt <= '0;
         else if (gap_cnt != PHASE_MAX)
            gap_cnt <= gap_cnt + 1'b1;
         // Two more high cycles after the strobe cycle
         if (sample_stb)
            hi_cnt <= 2'(`TART_TEST_PIN_HI - 1);
         else if (hi_cnt != '0)
            hi_cnt <= hi_cnt - 1'b1;
      end
   end

   assign rx_clk_test_pin = sample_stb | (hi_cnt != '0);

   // ----------------------------------------
   // Data sources
   // ----------------------------------------
   always_ff @(posedge fpga_clk)
   begin
      ant_q <= antenna;   // One cycle lag from pins
   end

   always_ff @(posedge fpga_clk or negedge rst_n)
   begin
      if (!rst_n)
         test_cnt <= '0;
      else if (sample_stb)
         test_cnt <= test_cnt + 1'b1;   // One step per sample
   end

   assign sample_word = debug_sel ? test_cnt : ant_q;

   // Strobes at least a full receiver period apart
   a_stb_spacing: assert property (@(posedge fpga_clk) disable iff (!rst_n)
      sample_stb |=> !sample_stb [*(`TART_SAMPLE_DIV - 1)]);

endmodule

/* hw/acq_scheduler.sv */
`timescale 1ns/1ps
`include "tart_consts.svh"

module acq_scheduler
(
   input  logic                     fpga_clk,
   input  logic                     rst_n,
   input  logic                     start_aq,      // Pulse from SPI
   input  logic                     soft_reset,    // Pulse from SPI
   input  logic                     sample_stb,
   input  logic [`TART_NUM_ANT-1:0] sample_word,
   input  logic                     sample_next,   // Host consumed one sample
   output logic [`TART_NUM_ANT-1:0] rd_data,
   output tart_pkg::acq_state_t     acq_state
);
   import tart_pkg::*;

   localparam logic [`TART_BUF_AW-1:0] LAST_ADDR = '1;

   logic [`TART_SRST_DEPTH-1:0] srst_q;    // Soft reset delay line
   logic                        soft_clr;  // Delayed soft reset
   logic                        wr_en;
   logic [`TART_BUF_AW-1:0]     wr_addr;
   logic [`TART_BUF_AW-1:0]     rd_addr;
   logic [`TART_NUM_ANT-1:0]    wr_data;

   // ----------------------------------------
   // Soft reset, three flops
   // ----------------------------------------
   always_ff @(posedge fpga_clk or negedge rst_n)
   begin
      if (!rst_n)
         srst_q <= '0;
      else
         srst_q <= {srst_q[`TART_SRST_DEPTH-2:0], soft_reset};
   end

   assign soft_clr = srst_q[`TART_SRST_DEPTH-1];

   // ----------------------------------------
   // Capture FSM and address counters
   // ----------------------------------------
   assign wr_en   = (acq_state == ST_CAPTURE) && sample_stb;  // Same cycle as strobe
   assign wr_data = sample_word;

   always_ff @(posedge fpga_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         acq_state <= ST_IDLE;
         wr_addr   <= '0;
         rd_addr   <= '0;
      end
      else if (soft_clr)
      begin
         acq_state <= ST_IDLE;
         wr_addr   <= '0;
         rd_addr   <= '0;
      end
      else
      begin
         case (acq_state)
            ST_IDLE:
            begin
               if (start_aq)
               begin
                  acq_state <= ST_CAPTURE;
                  wr_addr   <= '0;
               end
            end
            ST_CAPTURE:
            begin
               if (wr_en)
               begin
                  wr_addr <= wr_addr + 1'b1;   // Wraps to 0 after 512th
                  if (wr_addr == LAST_ADDR)
                     acq_state <= ST_FULL;
               end
            end
            ST_FULL, ST_DRAIN:
            begin
               if (sample_next)
               begin
                  rd_addr   <= rd_addr + 1'b1;
                  acq_state <= (rd_addr == LAST_ADDR) ? ST_IDLE : ST_DRAIN;
               end
            end
            default: acq_state <= ST_IDLE;
         endcase
      end
   end

   sample_store #(.DW(`TART_NUM_ANT), .AW(`TART_BUF_AW)) u_store
   (
      .fpga_clk (fpga_clk),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .rd_addr  (rd_addr),
      .wr_data  (wr_data),
      .rd_data  (rd_data)
   );

   // Held buffer never written without a new start from idle
   a_wr_capture_only: assert property (@(posedge fpga_clk) disable iff (!rst_n)
      wr_en |-> (acq_state == ST_CAPTURE) && !($past(acq_state) inside {ST_FULL, ST_DRAIN}));

   // Read pointer moves only while draining or on soft reset
   a_rd_addr_hold: assert property (@(posedge fpga_clk) disable iff (!rst_n)
      $changed(rd_addr) |-> ($past(acq_state) inside {ST_FULL, ST_DRAIN}) || $past(soft_clr));

endmodule

/* hw/spi_slave.sv */
`timescale 1ns/1ps
`include "tart_consts.svh"

module spi_slave
(
   input  logic                     fpga_clk,
   input  logic                     rst_n,
   input  logic                     spi_sck,
   input  logic                     spi_ssel,       // Active low
   input  logic                     spi_mosi,
   output logic                     spi_miso,
   input  tart_pkg::acq_state_t     acq_state,
   input  logic [`TART_NUM_ANT-1:0] rd_data,        // Current buffer sample
   output logic                     start_aq,
   output logic                     soft_reset,
   output logic                     debug_sel,
   output logic [`TART_DELAY_W-1:0] sample_delay,
   output logic                     sample_next
);
   import tart_pkg::*;

   localparam int         SMP_BYTES = `TART_BYTES_PER_SAMPLE;
   localparam logic [3:0] LAST_BIT  = 4'(`TART_SPI_BITS - 1);

   logic [2:0] sck_q;      // Two sync stages plus edge detect
   logic [1:0] ssel_q;
   logic [1:0] mosi_q;
   logic       sck_rise;
   logic       sck_fall;
   logic       frame_on;   // Select asserted
   logic [3:0] bit_cnt;
   logic [7:0] shift_in;
   logic [7:0] shift_out;
   logic [7:0] rx_byte;    // Byte including the bit on this edge
   logic [7:0] tx_byte;    // Next byte for MISO
   logic [7:0] status_byte;
   logic       first_byte; // Command byte pending
   logic       cmd_wr;
   spi_reg_t   cmd_addr;
   logic [1:0] data_idx;   // Byte within REG_DATA sample

   // ----------------------------------------
   // Input synchronizers
   // ----------------------------------------
   always_ff @(posedge fpga_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sck_q  <= '0;
         ssel_q <= '1;     // Deselected
         mosi_q <= '0;
      end
      else
      begin
         sck_q  <= {sck_q[1:0], spi_sck};
         ssel_q <= {ssel_q[0], spi_ssel};
         mosi_q <= {mosi_q[0], spi_mosi};
      end
   end

   assign sck_rise = sck_q[1] & ~sck_q[2];
   assign sck_fall = ~sck_q[1] & sck_q[2];
   assign frame_on = ~ssel_q[1];
   assign rx_byte  = {shift_in[6:0], mosi_q[1]};
   assign spi_miso = shift_out[7];   // MSB first

   // ----------------------------------------
   // Read data mux
   // ----------------------------------------
   always_comb
   begin
      status_byte                    = '0;
      status_byte[`TART_STATUS_MARK] = 1'b1;
      status_byte[`TART_STAT_DEBUG]  = debug_sel;
      status_byte[`TART_STAT_FULL]   = (acq_state == ST_FULL);
      status_byte[2:0]               = acq_state;
      tx_byte                        = '0;
      case (cmd_addr)
         REG_STATUS:  tx_byte = status_byte;
         REG_CONTROL: tx_byte[`TART_CTRL_DEBUG] = debug_sel;   // Pulse bits read 0
         REG_DELAY:   tx_byte = 8'(sample_delay);
         REG_DATA:    tx_byte = rd_data[8 * (SMP_BYTES - 1 - data_idx) +: 8];
         default:     tx_byte = '0;
      endcase
   end

   // ----------------------------------------
   // Frame, command decode and registers
   // ----------------------------------------
   always_ff @(posedge fpga_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         bit_cnt      <= '0;
         shift_in     <= '0;
         shift_out    <= '0;
         first_byte   <= 1'b1;
         cmd_wr       <= 1'b0;
         cmd_addr     <= REG_STATUS;
         data_idx     <= '0;
         debug_sel    <= 1'b0;
         sample_delay <= '0;
         start_aq     <= 1'b0;
         soft_reset   <= 1'b0;
         sample_next  <= 1'b0;
      end
      else
      begin
         start_aq    <= 1'b0;   // Pulses last one cycle
         soft_reset  <= 1'b0;
         sample_next <= 1'b0;
         if (!frame_on)
         begin
            bit_cnt    <= '0;
            first_byte <= 1'b1;
            data_idx   <= '0;
            shift_out  <= '0;
         end
         else if (sck_rise)
         begin
            shift_in <= rx_byte;
            if (bit_cnt == LAST_BIT)
            begin
               bit_cnt <= '0;
               if (first_byte)
               begin
                  first_byte <= 1'b0;
                  cmd_wr     <= rx_byte[`TART_CMD_WR_BIT];
                  cmd_addr   <= spi_reg_t'(rx_byte[2:0]);
               end
               else if (cmd_wr)
               begin
                  if (cmd_addr == REG_CONTROL)
                  begin
                     // Soft reset write leaves debug alone
                     if (rx_byte[`TART_CTRL_SRST])
                        soft_reset <= 1'b1;
                     else
                     begin
                        debug_sel <= rx_byte[`TART_CTRL_DEBUG];
                        start_aq  <= rx_byte[`TART_CTRL_START];
                     end
                  end
                  else if (cmd_addr == REG_DELAY)
                     sample_delay <= rx_byte[`TART_DELAY_W-1:0];
               end
               else if (cmd_addr == REG_DATA)
               begin
                  if (data_idx == 2'(SMP_BYTES - 1))
                  begin
                     data_idx    <= '0;
                     sample_next <= 1'b1;   // Last byte of sample done
                  end
                  else
                     data_idx <= data_idx + 1'b1;
               end
            end
            else
               bit_cnt <= bit_cnt + 1'b1;
         end
         else if (sck_fall)
         begin
            // Byte boundary loads next byte, otherwise shift
            if (bit_cnt == '0)
               shift_out <= tx_byte;
            else
               shift_out <= {shift_out[6:0], 1'b0};
         end
      end
   end

   a_bit_cnt_range: assert property (@(posedge fpga_clk) disable iff (!rst_n)
      bit_cnt < 4'(`TART_SPI_BITS));

endmodule

/* hw/tart_top.sv */
`timescale 1ns/1ps
`include "tart_consts.svh"

module tart_top
(
   input  logic                     fpga_clk,
   input  logic                     rst_n,
   input  logic [`TART_NUM_ANT-1:0] antenna,          // Radio data bus
   input  logic                     spi_sck,
   input  logic                     spi_ssel,
   input  logic                     spi_mosi,
   output logic                     spi_miso,
   output logic                     rx_clk_test_pin   // Delayed sample strobe view
);
   import tart_pkg::*;

   // ----------------------------------------
   // Interconnect
   // ----------------------------------------
   logic                     sample_stb;
   logic [`TART_NUM_ANT-1:0] sample_word;
   logic                     debug_sel;
   logic [`TART_DELAY_W-1:0] sample_delay;
   logic                     start_aq;
   logic                     soft_reset;    // Scheduler only
   logic                     sample_next;
   logic [`TART_NUM_ANT-1:0] rd_data;
   acq_state_t               acq_state;

   // Input side
   antenna_capture u_capture
   (
      .fpga_clk        (fpga_clk),
      .rst_n           (rst_n),
      .antenna         (antenna),
      .debug_sel       (debug_sel),
      .sample_delay    (sample_delay),
      .sample_stb      (sample_stb),
      .sample_word     (sample_word),
      .rx_clk_test_pin (rx_clk_test_pin)
   );

   // Buffer and capture control
   acq_scheduler u_sched
   (
      .fpga_clk    (fpga_clk),
      .rst_n       (rst_n),
      .start_aq    (start_aq),
      .soft_reset  (soft_reset),
      .sample_stb  (sample_stb),
      .sample_word (sample_word),
      .sample_next (sample_next),
      .rd_data     (rd_data),
      .acq_state   (acq_state)
   );

   // Host link
   spi_slave u_spi
   (
      .fpga_clk     (fpga_clk),
      .rst_n        (rst_n),
      .spi_sck      (spi_sck),
      .spi_ssel     (spi_ssel),
      .spi_mosi     (spi_mosi),
      .spi_miso     (spi_miso),
      .acq_state    (acq_state),
      .rd_data      (rd_data),
      .start_aq     (start_aq),
      .soft_reset   (soft_reset),
      .debug_sel    (debug_sel),
      .sample_delay (sample_delay),
      .sample_next  (sample_next)
   );

endmodule

/* bench/tart_tb.sv */
`timescale 1ns/1ps
`include "tart_consts.svh"

module tart_tb;
   import tart_pkg::*;

   localparam int HALF       = 4;     // SCK half period in fpga_clk cycles
   localparam int POLL_LIMIT = 100;   // Status reads before giving up
   localparam int PIN_LIMIT  = 40;    // Cycles to see one test pin period
   localparam int NSAMP      = 1 << `TART_BUF_AW;

   logic                     fpga_clk;
   logic                     rst_n;
   logic [`TART_NUM_ANT-1:0] antenna;
   logic                     spi_sck;
   logic                     spi_ssel;
   logic                     spi_mosi;
   wire                      spi_miso;
   wire                      rx_clk_test_pin;

   int                       value_errors = 0;
   int                       prop_errors  = 0;
   logic                     timed_out    = 1'b0;
   logic [15:0]              lfsr_state   = 16'd29;
   logic [`TART_NUM_ANT-1:0] samples [0:NSAMP-1];   // Last stream from REG_DATA

   tart_top UUT
   (
      .fpga_clk        (fpga_clk),
      .rst_n           (rst_n),
      .antenna         (antenna),
      .spi_sck         (spi_sck),
      .spi_ssel        (spi_ssel),
      .spi_mosi        (spi_mosi),
      .spi_miso        (spi_miso),
      .rx_clk_test_pin (rx_clk_test_pin)
   );

   initial fpga_clk = 1'b0;
   always #50 fpga_clk = ~fpga_clk;   // 100 ns period

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   // Fibonacci LFSR x^16+x^14+x^13+x^11, one step per bit
   function automatic logic [23:0] rand_bits(input int n);
      logic [23:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         r          = {r[22:0], fb};
      end
      return r;
   endfunction

   // Mark, two zeros, debug, full, state
   function automatic logic [7:0] status_expect(input logic dbg, input acq_state_t st);
      return {1'b1, 2'b00, dbg, (st == ST_FULL), st};
   endfunction

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      assert (act === exp)
      else
      begin
         value_errors = value_errors + 1;
         $display("[ERROR] %s: expected %02h, actual %02h", name, exp, act);
      end
   endtask

   task automatic check_word(input string name, input logic [23:0] exp, input logic [23:0] act);
      assert (act === exp)
      else
      begin
         value_errors = value_errors + 1;
         $display("[ERROR] %s: expected %06h, actual %06h", name, exp, act);
      end
   endtask

   // Flag a hang, watchdog below ends the run before the next edge
   task automatic give_up(input string what);
      $display("Timeout while %s", what);
      timed_out = 1'b1;
      @(posedge fpga_clk);
   endtask

   // ----------------------------------------
   // SPI host, mode 0
   // ----------------------------------------
   task automatic half_period();
      repeat (HALF) @(posedge fpga_clk);
   endtask

   task automatic frame_begin();
      @(posedge fpga_clk);
      spi_ssel <= 1'b0;
      half_period();
   endtask

   task automatic frame_end();
      half_period();
      spi_ssel <= 1'b1;
      half_period();
   endtask

   task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
      rx = '0;
      for (int i = 7; i >= 0; i--)
      begin
         spi_mosi <= tx[i];            // Changes with SCK low
         half_period();
         rx = {rx[6:0], spi_miso};     // Sample at the rising edge
         spi_sck <= 1'b1;
         half_period();
         spi_sck <= 1'b0;
      end
   endtask

   task automatic reg_write(input spi_reg_t addr, input logic [7:0] data);
      logic [7:0] dummy;
      frame_begin();
      xfer_byte({1'b1, 4'b0000, addr}, dummy);
      xfer_byte(data, dummy);
      frame_end();
   endtask

   task automatic reg_read(input spi_reg_t addr, output logic [7:0] data);
      logic [7:0] dummy;
      frame_begin();
      xfer_byte({1'b0, 4'b0000, addr}, dummy);
      xfer_byte(8'h00, data);
      frame_end();
   endtask

   // One frame, three bytes per sample MSB first
   task automatic stream_samples();
      logic [7:0]  rx;
      logic [23:0] word;
      frame_begin();
      xfer_byte({5'b00000, REG_DATA}, rx);
      for (int s = 0; s < NSAMP; s++)
      begin
         word = '0;
         for (int b = 0; b < `TART_BYTES_PER_SAMPLE; b++)
         begin
            xfer_byte(8'h00, rx);
            word = {word[15:0], rx};
         end
         samples[s] = word;
      end
      frame_end();
   endtask

   task automatic wait_full();
      logic [7:0] st;
      int         polls;
      polls = 0;
      reg_read(REG_STATUS, st);
      while (!(st[`TART_STAT_FULL] && st[2:0] == ST_FULL) && polls < POLL_LIMIT)
      begin
         polls = polls + 1;
         reg_read(REG_STATUS, st);
      end
      if (polls >= POLL_LIMIT)
         give_up("polling status for a full buffer");
   endtask

   // One full period of the receiver clock view
   task automatic measure_test_pin(output int hi_cycles, output int lo_cycles);
      int guard;
      guard     = 0;
      hi_cycles = 0;
      lo_cycles = 0;
      while (rx_clk_test_pin !== 1'b0 && guard < PIN_LIMIT)
      begin
         @(posedge fpga_clk);
         guard = guard + 1;
      end
      while (rx_clk_test_pin !== 1'b1 && guard < PIN_LIMIT)
      begin
         @(posedge fpga_clk);
         guard = guard + 1;
      end
      while (rx_clk_test_pin === 1'b1 && guard < PIN_LIMIT)
      begin
         hi_cycles = hi_cycles + 1;
         @(posedge fpga_clk);
         guard = guard + 1;
      end
      while (rx_clk_test_pin === 1'b0 && guard < PIN_LIMIT)
      begin
         lo_cycles = lo_cycles + 1;
         @(posedge fpga_clk);
         guard = guard + 1;
      end
      if (guard >= PIN_LIMIT)
         give_up("measuring rx_clk_test_pin");
   endtask

   // Three high then at least three low after every rise
   a_test_pin_shape: assert property (@(posedge fpga_clk) disable iff (!rst_n)
      $rose(rx_clk_test_pin) |-> rx_clk_test_pin ##1 rx_clk_test_pin ##1 rx_clk_test_pin
         ##1 !rx_clk_test_pin ##1 !rx_clk_test_pin ##1 !rx_clk_test_pin)
   else
   begin
      prop_errors = prop_errors + 1;
      $display("rx_clk_test_pin waveform broken at %0t", $time);
   end

   initial
   begin
      wait (timed_out);
      $display("Run stopped: %0d value errors, %0d property errors", value_errors, prop_errors);
      $display("Simulation failed");
      $finish;
   end

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial
   begin
      logic [7:0]  rd;
      logic [23:0] r;
      logic [2:0]  delay_val;
      logic [23:0] ant_val;
      int          hi;
      int          lo;
      rst_n    = 1'b0;
      antenna  = '0;
      spi_sck  = 1'b0;
      spi_ssel = 1'b1;   // Deselected
      spi_mosi = 1'b0;
      repeat (2) @(posedge fpga_clk);
      rst_n <= 1'b1;

      reg_read(REG_STATUS, rd);
      check_byte("status_after_reset", status_expect(1'b0, ST_IDLE), rd);

      ant_val   = rand_bits(24);   // Bus value for the real-source capture
      r         = rand_bits(3);
      delay_val = r[2:0];
      reg_write(REG_DELAY, {5'b00000, delay_val});
      reg_read(REG_DELAY, rd);
      check_byte("delay_readback", {5'b00000, delay_val}, rd);
      reg_write(REG_CONTROL, 8'h02);              // Debug only
      reg_read(REG_CONTROL, rd);
      check_byte("control_readback", 8'h02, rd);
      measure_test_pin(hi, lo);
      check_word("test_pin_high", 24'd3, 24'(hi));
      check_word("test_pin_low", 24'd3, 24'(lo));

      // Real antenna source, constant bus
      antenna <= ant_val;
      reg_write(REG_CONTROL, 8'h01);              // Start, debug off
      wait_full();
      reg_read(REG_STATUS, rd);
      check_byte("status_full_real", status_expect(1'b0, ST_FULL), rd);
      stream_samples();
      for (int i = 0; i < NSAMP; i++)
         check_word("real_sample", ant_val, samples[i]);
      reg_read(REG_STATUS, rd);
      check_byte("status_idle_real", status_expect(1'b0, ST_IDLE), rd);

      // Test counter source
      reg_write(REG_CONTROL, 8'h03);
      wait_full();
      stream_samples();
      for (int i = 1; i < NSAMP; i++)
         check_word("counter_sample", samples[i-1] + 24'd1, samples[i]);
      reg_read(REG_STATUS, rd);
      check_byte("status_idle_counter", status_expect(1'b1, ST_IDLE), rd);

      // Second start during capture
      reg_write(REG_CONTROL, 8'h03);
      reg_read(REG_STATUS, rd);
      check_byte("status_capture", status_expect(1'b1, ST_CAPTURE), rd);
      reg_write(REG_CONTROL, 8'h03);
      wait_full();
      stream_samples();
      for (int i = 1; i < NSAMP; i++)
         check_word("restart_sample", samples[i-1] + 24'd1, samples[i]);
      reg_read(REG_STATUS, rd);
      check_byte("status_idle_restart", status_expect(1'b1, ST_IDLE), rd);

      // Start while full
      reg_write(REG_CONTROL, 8'h03);
      wait_full();
      reg_write(REG_CONTROL, 8'h03);
      reg_read(REG_STATUS, rd);
      check_byte("status_full_start", status_expect(1'b1, ST_FULL), rd);

      // Soft reset clears scheduler only
      reg_write(REG_CONTROL, 8'h80);
      reg_read(REG_STATUS, rd);
      check_byte("status_soft_reset", status_expect(1'b1, ST_IDLE), rd);
      reg_read(REG_DELAY, rd);
      check_byte("delay_kept", {5'b00000, delay_val}, rd);
      reg_read(REG_CONTROL, rd);
      check_byte("debug_kept", 8'h02, rd);

      repeat (10) @(posedge fpga_clk);
      $display("Run done: %0d value errors, %0d property errors", value_errors, prop_errors);
      if (value_errors == 0 && prop_errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* list.f */
+incdir+include
hw/tart_pkg.sv
hw/sample_store.sv
hw/antenna_capture.sv
hw/acq_scheduler.sv
hw/spi_slave.sv
hw/tart_top.sv
bench/tart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the TART capture testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
   --top-module tart_tb -f list.f -o tart_sim \
   || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tart_sim)
echo "$sim_out"

grep -q "Simulation completed successfully" <<< "$sim_out" && exit 0 || exit 1
